//--- design/flow_macros.svh
// Global sizing for the flow router
//   FLOW_NUM_PORTS   number of egress ports
//   FLOW_DATA_WIDTH  bits per data word
//   FLOW_COUNT_WIDTH bits per delivered-beat counter

`ifndef FLOW_MACROS_SVH
`define FLOW_MACROS_SVH

// ------------------------------------------------------------
// Port fan-out
// ------------------------------------------------------------
// Keep this a power of two so every select code maps to a port
`define FLOW_NUM_PORTS 4

// ------------------------------------------------------------
// Datapath and statistics widths
// ------------------------------------------------------------
`define FLOW_DATA_WIDTH 32

// Counters wrap silently at this width
`define FLOW_COUNT_WIDTH 16

`endif

//--- design/flow_pkg.sv
// Shared types for the flow router
//   port_id_t     destination port number
//   flow_data_t   one data word
//   flow_beat_t   ingress beat, destination plus data
//   beat_count_t  one per-port delivery counter

`include "flow_macros.svh"

package flow_pkg;

  // ------------------------------------------------------------
  // Derived widths
  // ------------------------------------------------------------
  // Select width follows the port count
  localparam int unsigned PORT_ID_WIDTH = $clog2(`FLOW_NUM_PORTS);

  // ------------------------------------------------------------
  // Scalar types
  // ------------------------------------------------------------
  // Destination port number carried in every beat
  typedef logic [PORT_ID_WIDTH-1:0] port_id_t;

  // Payload word, copied unchanged from push to pop
  typedef logic [`FLOW_DATA_WIDTH-1:0] flow_data_t;

  // Delivered-beat count for one egress port
  typedef logic [`FLOW_COUNT_WIDTH-1:0] beat_count_t;

  // ------------------------------------------------------------
  // Ingress beat
  // ------------------------------------------------------------
  // Destination sits in the upper bits
  // Data word fills the lower bits
  typedef struct packed {
    port_id_t   dest;
    flow_data_t data;
  } flow_beat_t;

endpackage

//--- design/flow_reg_fwd.sv
// Forward pipeline register with ready-valid on both sides
//   One payload slot plus a valid flag
//   Payload type set per instance through a type parameter
//   Full throughput by reloading in the cycle the slot drains

`timescale 1ns/1ps

module flow_reg_fwd #(
  // Payload carried through the stage
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,

  // Upstream side
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_payload,

  // Downstream side
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_payload
);

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------
  // Set while the slot holds a beat not yet taken downstream
  logic     full_q;

  // Held beat
  payload_t payload_q;

  // Upstream transfer in this cycle
  logic     in_fire;

  // ------------------------------------------------------------
  // Handshake
  // ------------------------------------------------------------
  // Room when empty or when the held beat leaves this cycle
  assign in_ready = !full_q || out_ready;
  assign in_fire  = in_valid && in_ready;

  // Valid flag
  // Slot takes the upstream valid whenever it can change
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (in_ready) begin
      full_q <= in_valid;
    end
  end

  // Payload only moves on an upstream transfer
  always_ff @(posedge clk) begin
    if (in_fire) begin
      payload_q <= in_payload;
    end
  end

  // ------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------
  assign out_valid   = full_q;
  assign out_payload = payload_q;

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  // An offered beat waits upstream unchanged until this stage takes it
  in_payload_held_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_payload)
  ) else $error("flow_reg_fwd: upstream beat changed or withdrawn while stalled");

  // Beats entering the stage are fully defined
  in_payload_known_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    in_fire |-> !$isunknown(in_payload)
  ) else $error("flow_reg_fwd: unknown bits in accepted payload");

endmodule

//--- design/flow_demux_select.sv
// Ready-valid demux steered by an explicit select
//   Valid goes to the selected port only
//   Ready comes back from the selected port
//   Data fans out to every port with zero cycle latency

`timescale 1ns/1ps

`include "flow_macros.svh"

module flow_demux_select (
  // Assertion clocking only
  input  logic                                      clk,
  input  logic                                      rst_n,

  // Port choice for the current push beat
  input  flow_pkg::port_id_t                        select,

  // Push side
  input  logic                                      push_valid,
  output logic                                      push_ready,
  input  flow_pkg::flow_data_t                      push_data,

  // Pop side, one lane per port
  input  logic [`FLOW_NUM_PORTS-1:0]                pop_ready,
  output logic [`FLOW_NUM_PORTS-1:0]                pop_valid,
  output flow_pkg::flow_data_t [`FLOW_NUM_PORTS-1:0] pop_data
);

  import flow_pkg::*;

  // ------------------------------------------------------------
  // Steering
  // ------------------------------------------------------------
  // Back-pressure from the chosen port only
  assign push_ready = pop_ready[select];

  // One-hot valid and replicated data
  // A data lane means nothing unless its valid is set
  always_comb begin
    for (int i = 0; i < `FLOW_NUM_PORTS; i++) begin
      pop_valid[i] = push_valid && (select == port_id_t'(i));
      pop_data[i]  = push_data;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  // Select must name an existing port whenever a beat is offered
  select_in_range_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    push_valid |-> !$isunknown(select) && (int'(select) < `FLOW_NUM_PORTS)
  ) else $error("flow_demux_select: select out of range");

  // A stalled beat must keep its port so valid cannot hop lanes
  select_stable_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    push_valid && !push_ready |=> $stable(select)
  ) else $error("flow_demux_select: select moved during stall");

endmodule

//--- design/flow_beat_counters.sv
// Per-port counters of completed pop handshakes
//   One counter per egress port
//   Increments on the edge that completes a transfer
//   Wraps at the counter width

`timescale 1ns/1ps

`include "flow_macros.svh"

module flow_beat_counters (
  input  logic                                       clk,
  input  logic                                       rst_n,

  // Observed egress handshake
  input  logic [`FLOW_NUM_PORTS-1:0]                 pop_valid,
  input  logic [`FLOW_NUM_PORTS-1:0]                 pop_ready,

  // Running totals
  output flow_pkg::beat_count_t [`FLOW_NUM_PORTS-1:0] beat_counts
);

  import flow_pkg::*;

  // ------------------------------------------------------------
  // Handshake detect
  // ------------------------------------------------------------
  // High in the cycle a port completes a transfer
  logic [`FLOW_NUM_PORTS-1:0] pop_fire;

  assign pop_fire = pop_valid & pop_ready;

  // ------------------------------------------------------------
  // Counters
  // ------------------------------------------------------------
  for (genvar p = 0; p < `FLOW_NUM_PORTS; p++) begin : g_count
    // Plain increment, overflow rolls back to zero
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        beat_counts[p] <= '0;
      end else if (pop_fire[p]) begin
        beat_counts[p] <= beat_counts[p] + beat_count_t'(1);
      end
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  // Counters stay defined once out of reset
  counts_known_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(beat_counts)
  ) else $error("flow_beat_counters: unknown bits in beat_counts");

endmodule

//--- design/flow_router_top.sv
// Flow router top level
//   Ingress forward register on the push stream
//   Select demux driven by the registered destination
//   One egress forward register per port
//   Per-port delivered-beat counters on the pop side

`timescale 1ns/1ps

`include "flow_macros.svh"

module flow_router_top (
  input  logic                                        clk,
  input  logic                                        rst_n,

  // Ingress stream
  input  logic                                        push_valid,
  output logic                                        push_ready,
  input  flow_pkg::flow_beat_t                        push_beat,

  // Egress streams, one lane per port
  output logic [`FLOW_NUM_PORTS-1:0]                  pop_valid,
  input  logic [`FLOW_NUM_PORTS-1:0]                  pop_ready,
  output flow_pkg::flow_data_t [`FLOW_NUM_PORTS-1:0]  pop_data,

  // Delivered beats per port
  output flow_pkg::beat_count_t [`FLOW_NUM_PORTS-1:0] beat_counts
);

  import flow_pkg::*;

  // ------------------------------------------------------------
  // Internal streams
  // ------------------------------------------------------------
  // Registered ingress beat
  logic                                 ing_valid;
  logic                                 ing_ready;
  flow_beat_t                           ing_beat;

  // Demux outputs into the egress registers
  logic       [`FLOW_NUM_PORTS-1:0]     dmx_valid;
  logic       [`FLOW_NUM_PORTS-1:0]     dmx_ready;
  flow_data_t [`FLOW_NUM_PORTS-1:0]     dmx_data;

  // ------------------------------------------------------------
  // Ingress stage
  // ------------------------------------------------------------
  // Holds the beat so its destination stays put while stalled
  flow_reg_fwd #(
    .payload_t (flow_beat_t)
  ) ingress_reg_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (push_valid),
    .in_ready    (push_ready),
    .in_payload  (push_beat),
    .out_valid   (ing_valid),
    .out_ready   (ing_ready),
    .out_payload (ing_beat)
  );

  // ------------------------------------------------------------
  // Steering
  // ------------------------------------------------------------
  // Blocked destination stalls everything behind it
  flow_demux_select demux_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .select     (ing_beat.dest),
    .push_valid (ing_valid),
    .push_ready (ing_ready),
    .push_data  (ing_beat.data),
    .pop_ready  (dmx_ready),
    .pop_valid  (dmx_valid),
    .pop_data   (dmx_data)
  );

  // ------------------------------------------------------------
  // Egress stages
  // ------------------------------------------------------------
  for (genvar p = 0; p < `FLOW_NUM_PORTS; p++) begin : g_egress
    // Destination is dropped here, the lane itself names the port
    flow_reg_fwd #(
      .payload_t (flow_data_t)
    ) egress_reg_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid    (dmx_valid[p]),
      .in_ready    (dmx_ready[p]),
      .in_payload  (dmx_data[p]),
      .out_valid   (pop_valid[p]),
      .out_ready   (pop_ready[p]),
      .out_payload (pop_data[p])
    );
  end

  // ------------------------------------------------------------
  // Statistics
  // ------------------------------------------------------------
  flow_beat_counters counters_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .pop_valid   (pop_valid),
    .pop_ready   (pop_ready),
    .beat_counts (beat_counts)
  );

endmodule

//--- tests/flow_router_tb.sv
// Testbench for the flow router
//   Clock, reset and pattern file loading
//   Randomized push pauses and pop back-pressure
//   Full-throughput burst with every pop_ready high
//   Per-port scoreboard queues with stall and latency checks
//   Final beat counter comparison

`timescale 1ns/1ps

`include "flow_macros.svh"

module flow_router_tb;

  import flow_pkg::*;

  // ------------------------------------------------------------
  // Constants and signals
  // ------------------------------------------------------------
  localparam int          NUM_PORTS   = `FLOW_NUM_PORTS;
  // Trailing beats sent with every pop_ready high
  localparam int          BURST_BEATS = 8;
  // Ingress plus egress register
  localparam int unsigned MIN_LATENCY = 2;

  logic                        clk;
  logic                        rst_n;
  logic                        push_valid;
  logic                        push_ready;
  flow_beat_t                  push_beat;
  logic [NUM_PORTS-1:0]        pop_valid;
  logic [NUM_PORTS-1:0]        pop_ready;
  flow_data_t [NUM_PORTS-1:0]  pop_data;
  beat_count_t [NUM_PORTS-1:0] beat_counts;

  // Beats and totals from the pattern file
  port_id_t    pat_dest [$];
  flow_data_t  pat_data [$];
  beat_count_t exp_counts [NUM_PORTS];

  // Scoreboard, one queue per port
  flow_data_t  exp_q [NUM_PORTS][$];
  int unsigned push_edge_q [NUM_PORTS][$];
  int unsigned pop_tally [NUM_PORTS] = '{default: 0};

  // Stall tracking per port
  logic [NUM_PORTS-1:0] stalled = '0;
  flow_data_t           held_data [NUM_PORTS] = '{default: '0};

  int unsigned cycle_count   = 0;
  int unsigned timeout_limit = 200;
  integer      seed;

  flow_router_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_valid  (push_valid),
    .push_ready  (push_ready),
    .push_beat   (push_beat),
    .pop_valid   (pop_valid),
    .pop_ready   (pop_ready),
    .pop_data    (pop_data),
    .beat_counts (beat_counts)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Reporting
  // ------------------------------------------------------------
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic compare_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("ERROR: %s actual=0x%0h expected=0x%0h",
                               name, actual, expected));
    end
  endtask

  // ------------------------------------------------------------
  // Pattern file
  // ------------------------------------------------------------
  task automatic load_patterns();
    integer      fd;
    integer      n;
    string       line;
    string       word;
    logic [31:0] f_dest;
    logic [31:0] f_data;
    logic [31:0] c0;
    logic [31:0] c1;
    logic [31:0] c2;
    logic [31:0] c3;
    bit          counts_seen;
    counts_seen = 1'b0;
    fd = $fopen("tests/flow_router_patterns.txt", "r");
    if (fd == 0) begin
      report_failure("Could not open the pattern file tests/flow_router_patterns.txt");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // Skip blank lines and comment lines
      if (n > 0 && line.len() > 0 && line[0] != "#" && $sscanf(line, "%s", word) == 1) begin
        if (word == "counts") begin
          n = $sscanf(line, "%s %h %h %h %h", word, c0, c1, c2, c3);
          if (n != 5) begin
            report_failure("The counts line of the pattern file is malformed");
          end
          exp_counts[0] = beat_count_t'(c0);
          exp_counts[1] = beat_count_t'(c1);
          exp_counts[2] = beat_count_t'(c2);
          exp_counts[3] = beat_count_t'(c3);
          counts_seen = 1'b1;
        end else begin
          n = $sscanf(line, "%h %h", f_dest, f_data);
          if (n != 2 || f_dest >= 32'(NUM_PORTS)) begin
            report_failure($sformatf("Bad beat line in the pattern file: %s", line));
          end
          pat_dest.push_back(port_id_t'(f_dest));
          pat_data.push_back(flow_data_t'(f_data));
        end
      end
    end
    $fclose(fd);
    if (!counts_seen || pat_dest.size() <= BURST_BEATS) begin
      report_failure("The pattern file lacks its counts line or has too few beats");
    end
  endtask

  // ------------------------------------------------------------
  // Scoreboard
  // ------------------------------------------------------------
  // Transfer completes on the coming edge, hence the plus one
  task automatic record_push(input flow_beat_t beat);
    exp_q[beat.dest].push_back(beat.data);
    push_edge_q[beat.dest].push_back(cycle_count + 1);
  endtask

  function automatic bit queues_empty();
    bit empty;
    empty = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (exp_q[p].size() != 0) empty = 1'b0;
    end
    return empty;
  endfunction

  // Sampled mid-cycle, inputs and DUT outputs are settled there
  task automatic watch_port(input int p);
    flow_data_t  want;
    int unsigned latency;
    // A stalled lane must hold valid and data
    if (stalled[p]) begin
      compare_value($sformatf("pop_valid[%0d]", p), 64'(pop_valid[p]), 64'(1));
      compare_value($sformatf("pop_data[%0d]", p), 64'(pop_data[p]), 64'(held_data[p]));
    end
    stalled[p]   = pop_valid[p] && !pop_ready[p];
    held_data[p] = pop_data[p];
    if (pop_valid[p] && pop_ready[p]) begin
      if (exp_q[p].size() == 0) begin
        report_failure($sformatf("Port %0d delivered a beat that was never sent to it", p));
      end else begin
        want    = exp_q[p].pop_front();
        latency = cycle_count + 1 - push_edge_q[p].pop_front();
        compare_value($sformatf("pop_data[%0d]", p), 64'(pop_data[p]), 64'(want));
        if (latency < MIN_LATENCY) begin
          report_failure($sformatf("Port %0d delivered a beat %0d cycles after its push",
                                   p, latency));
        end
        pop_tally[p]++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        watch_port(p);
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      report_failure($sformatf("Timeout, the run did not finish within %0d cycles",
                               timeout_limit));
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    int          idx;
    int          burst_start;
    bit          burst;
    bit          took;
    logic [31:0] r;
    seed       = 32'h3c79;
    rst_n      = 1'b0;
    push_valid = 1'b0;
    push_beat  = '0;
    pop_ready  = '0;
    load_patterns();
    timeout_limit = 20 * pat_dest.size() + 200;

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Quiet outputs before the first beat
    @(negedge clk);
    compare_value("pop_valid", 64'(pop_valid), 64'(0));
    compare_value("push_ready", 64'(push_ready), 64'(1));
    for (int p = 0; p < NUM_PORTS; p++) begin
      compare_value($sformatf("beat_counts[%0d]", p), 64'(beat_counts[p]), 64'(0));
    end
    @(posedge clk);
    #1;

    burst_start = pat_dest.size() - BURST_BEATS;
    idx         = 0;
    while (idx < pat_dest.size()) begin
      burst = (idx >= burst_start);
      r     = $random(seed);
      // Roughly three in four lanes ready outside the burst
      pop_ready = burst ? '1 : (r[3:0] | r[7:4]);
      // A held beat keeps its payload until taken
      if (!push_valid) begin
        r = $random(seed);
        if (burst || r[1:0] != 2'b00) begin
          push_valid     = 1'b1;
          push_beat.dest = pat_dest[idx];
          push_beat.data = pat_data[idx];
        end
      end
      @(negedge clk);
      // Full throughput, one beat per cycle
      if (burst) begin
        compare_value("push_ready", 64'(push_ready), 64'(1));
      end
      took = push_valid && push_ready;
      if (took) begin
        record_push(push_beat);
        idx++;
      end
      @(posedge clk);
      #1;
      if (took) push_valid = 1'b0;
    end

    // Drain under random back-pressure
    while (!queues_empty()) begin
      r         = $random(seed);
      pop_ready = r[3:0] | r[7:4];
      @(posedge clk);
      #1;
    end

    compare_value("pop_valid", 64'(pop_valid), 64'(0));
    for (int p = 0; p < NUM_PORTS; p++) begin
      compare_value($sformatf("beat_counts[%0d]", p), 64'(beat_counts[p]),
                    64'(exp_counts[p]));
      compare_value($sformatf("beat_counts[%0d]", p), 64'(beat_counts[p]),
                    64'(pop_tally[p]));
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- compile.f
+incdir+design
design/flow_pkg.sv
design/flow_reg_fwd.sv
design/flow_demux_select.sv
design/flow_beat_counters.sv
design/flow_router_top.sv
tests/flow_router_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the flow router testbench with Verilator
# Exit status is non-zero when the build, the run or any check fails

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
FAIL_MSG='Test failures found'

echo "Compiling with Verilator"
verilator --binary --assert -j 0 \
  --top-module flow_router_tb \
  -Mdir "$BUILD_DIR" \
  -f compile.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

echo "Running simulation"
"./$BUILD_DIR/Vflow_router_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

# The log decides the verdict
if grep -q "$FAIL_MSG" "$LOG_FILE"; then
  echo "Simulation FAILED"
  exit 1
fi

# A crash without the fail message still counts as a failure
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

echo "Simulation PASSED"
exit 0

//--- tests/flow_router_patterns.txt
# columns: dest (hex port number) data (hex word), one beat per line in push order
# closing line: the keyword counts, then the expected beats for ports 0 1 2 3
0 a5a50000
1 11110001
2 22220002
3 33330003
1 11110004
1 11110005
0 a5a50006
3 33330007
2 22220008
0 a5a50009
3 3333000a
1 1111000b
2 2222000c
1 1111000d
0 a5a5000e
2 2222000f
# the last 8 beats form the full-throughput burst
0 deadbe10
1 deadbe11
2 deadbe12
3 deadbe13
3 deadbe14
2 deadbe15
1 deadbe16
0 deadbe17
# expected per-port totals
counts 6 7 6 5
